/* ex_stage.f */
+incdir+tb
hdl/rv_isa_pkg.sv
hdl/ex_stage_pkg.sv
hdl/ex_issue_reg.sv
hdl/operand_forward.sv
hdl/alu_decode.sv
hdl/ex_alu.sv
hdl/branch_unit.sv
hdl/ex_result.sv
hdl/ex_stage.sv
tb/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/ex_stage_pkg.sv
  - hdl/ex_issue_reg.sv
  - hdl/operand_forward.sv
  - hdl/alu_decode.sv
  - hdl/ex_alu.sv
  - hdl/branch_unit.sv
  - hdl/ex_result.sv
  - hdl/ex_stage.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/ex_stage_tb.sv

/* tb/ex_model.svh */
`ifndef ex_model_svh
`define ex_model_svh

// reference model of the EX stage
// written from the ISA rules, shares nothing with the RTL

// one source operand after bypassing
// x0 never forwarded, the younger MEM stage beats WB
function automatic data_t exp_fwd(input reg_idx_t idx, input data_t rf_val,
                                  input bypass_t mem_src, input bypass_t wb_src);
    if (idx == '0) return rf_val;
    if (mem_src.wr && mem_src.rd == idx) return mem_src.data;
    if (wb_src.wr && wb_src.rd == idx) return wb_src.data;
    return rf_val;
endfunction

// classes that really read rs2
function automatic logic exp_rs2_live(input inst_class_e cls);
    return cls inside {cls_branch, cls_store, cls_op, cls_op_w};
endfunction

// alu result as MEM should see it
function automatic data_t exp_alu(input id_ex_t inst, input data_t s1, input data_t s2);
    data_t              b;
    data_t              r;
    logic               word;
    logic               reg_form;
    logic               alt;
    logic [5:0]         sh;
    logic signed [31:0] ws;
    case (inst.inst_class)
        cls_lui:             return inst.imm;
        cls_auipc:           return inst.pc + inst.imm;
        cls_jal, cls_jalr:   return inst.pc + 64'd4;
        cls_load, cls_store: return s1 + inst.imm;
        // compare runs as a subtract
        cls_branch:          return s1 - s2;
        default: ;
    endcase
    word     = inst.inst_class inside {cls_op_w, cls_op_imm_w};
    reg_form = inst.inst_class inside {cls_op, cls_op_w};
    alt      = inst.imm[10];
    b        = reg_form ? s2 : inst.imm;
    // shamt is 5 bits for the w forms
    sh       = word ? {1'b0, b[4:0]} : b[5:0];
    case (inst.funct3)
        3'b000: r = (reg_form && alt) ? s1 - b : s1 + b;
        3'b001: r = s1 << sh;
        3'b010: r = {63'b0, $signed(s1) < $signed(b)};
        3'b011: r = {63'b0, s1 < b};
        3'b100: r = s1 ^ b;
        3'b101: begin
            ws = s1[31:0];
            if (word && alt) begin
                r = {32'b0, ws >>> sh};
            end else if (word) begin
                r = {32'b0, s1[31:0] >> sh};
            end else if (alt) begin
                r = $signed(s1) >>> sh;
            end else begin
                r = s1 >> sh;
            end
        end
        3'b110: r = s1 | b;
        default: r = s1 & b;
    endcase
    // w forms sign extend bit 31
    return word ? {{32{r[31]}}, r[31:0]} : r;
endfunction

// misprediction rule, backward taken / forward not taken
function automatic redirect_t exp_redirect(input id_ex_t inst, input data_t s1,
                                           input data_t s2);
    redirect_t rd_out;
    logic      taken;
    case (inst.funct3)
        f3_beq:  taken = s1 == s2;
        f3_bne:  taken = s1 != s2;
        f3_blt:  taken = $signed(s1) < $signed(s2);
        f3_bge:  taken = $signed(s1) >= $signed(s2);
        f3_bltu: taken = s1 < s2;
        default: taken = s1 >= s2;
    endcase
    rd_out.update = 1'b0;
    rd_out.target = '0;
    if (inst.inst_class == cls_jalr) begin
        rd_out.update = 1'b1;
        rd_out.target = s1 + inst.imm;
    end else if (inst.inst_class == cls_branch && taken != inst.imm[12]) begin
        rd_out.update = 1'b1;
        rd_out.target = taken ? inst.pc + inst.imm : inst.pc + 64'd4;
    end
    return rd_out;
endfunction

`endif

/* tb/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    localparam int reset_cycles = 16;
    localparam int test_cycles  = 4000;
    // stimulus length plus drain and some slack
    localparam int cycle_limit  = reset_cycles + test_cycles + 100;

    logic      clk;
    logic      reset;
    logic      branch_flush;
    logic      valid_id_ex;
    logic      ready_ex_mem;
    id_ex_t    id_ex;
    bypass_t   mem_bypass;
    bypass_t   wb_bypass;
    logic      ready_id_ex;
    logic      valid_ex_mem;
    ex_mem_t   ex_mem;
    redirect_t redirect;

    // model copy of the issue register
    logic      m_valid;
    id_ex_t    m_inst;
    logic      last_clear;
    logic      held;
    data_t     last_pc;

    integer    seed;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    `include "ex_model.svh"

    ex_stage ex_stage_i (
        .clk          (clk),
        .reset        (reset),
        .branch_flush (branch_flush),
        .valid_id_ex  (valid_id_ex),
        .ready_ex_mem (ready_ex_mem),
        .id_ex        (id_ex),
        .mem_bypass   (mem_bypass),
        .wb_bypass    (wb_bypass),
        .ready_id_ex  (ready_id_ex),
        .valid_ex_mem (valid_ex_mem),
        .ex_mem       (ex_mem),
        .redirect     (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    // small index range so bypasses collide often
    task automatic rand_bypass(output bypass_t bp);
        logic [31:0] r;
        r = $random(seed);
        bp.wr   = r[0];
        bp.rd   = {3'b0, r[2:1]};
        bp.data = {$random(seed), $random(seed)};
    endtask

    task automatic rand_inst(output id_ex_t inst);
        logic [31:0] r;
        int unsigned pick;
        pick            = $unsigned($random(seed)) % 11;
        inst.inst_class = inst_class_e'(pick);
        r               = $random(seed);
        inst.funct3     = r[2:0];
        inst.rd         = {3'b0, r[4:3]};
        inst.rs1        = {3'b0, r[6:5]};
        inst.rs2        = {3'b0, r[8:7]};
        // only the six legal compares
        if (inst.inst_class == cls_branch) begin
            pick        = $unsigned($random(seed)) % 6;
            inst.funct3 = (pick < 2) ? pick[2:0] : pick[2:0] + 3'd2;
        end
        r = $random(seed);
        if (inst.inst_class inside {cls_lui, cls_auipc}) begin
            inst.imm = {{32{r[31]}}, r[31:12], 12'b0};
        end else begin
            inst.imm = {{51{r[12]}}, r[12:0]};
        end
        inst.pc    = {$random(seed), $random(seed) & 32'hffff_fffc};
        inst.src_a = {$random(seed), $random(seed)};
        inst.src_b = {$random(seed), $random(seed)};
        // equal operands now and then so beq/bge take
        if (($random(seed) & 3) == 0) inst.src_b = inst.src_a;
    endtask

    task automatic drive_random();
        id_ex_t  inst;
        bypass_t bp_mem;
        bypass_t bp_wb;
        rand_inst(inst);
        rand_bypass(bp_mem);
        rand_bypass(bp_wb);
        id_ex        <= inst;
        mem_bypass   <= bp_mem;
        wb_bypass    <= bp_wb;
        valid_id_ex  <= ($random(seed) & 3) != 0;
        // ready high about 3 in 4
        ready_ex_mem <= ($random(seed) & 3) != 0;
        branch_flush <= ($random(seed) & 15) == 0;
    endtask

    // issue register load, hold and flush
    always @(posedge clk) begin
        last_clear <= reset || branch_flush;
        held       <= !reset && !branch_flush && !ready_ex_mem;
        if (reset || branch_flush) begin
            m_valid <= 1'b0;
        end else if (ready_ex_mem) begin
            m_valid <= valid_id_ex;
            m_inst  <= id_ex;
        end
    end

    task automatic check_outputs();
        data_t     s1;
        data_t     s2;
        redirect_t rexp;
        s1 = exp_fwd(m_inst.rs1, m_inst.src_a, mem_bypass, wb_bypass);
        s2 = m_inst.src_b;
        if (exp_rs2_live(m_inst.inst_class)) begin
            s2 = exp_fwd(m_inst.rs2, m_inst.src_b, mem_bypass, wb_bypass);
        end
        rexp = exp_redirect(m_inst, s1, s2);
        check_val("handshake ready_id_ex", ready_ex_mem, ready_id_ex);
        check_val("issue valid_ex_mem", m_valid, valid_ex_mem);
        // fires only on the leaving edge
        check_val("branch redirect.update", rexp.update && m_valid && ready_ex_mem,
                  redirect.update);
        if (last_clear) begin
            check_val("flush valid_ex_mem", 1'b0, valid_ex_mem);
            check_val("flush redirect.update", 1'b0, redirect.update);
        end
        if (m_valid === 1'b1) begin
            check_val({"alu alu_result ", m_inst.inst_class.name()}, exp_alu(m_inst, s1, s2),
                      ex_mem.alu_result);
            check_val({"forward store_data ", m_inst.inst_class.name()}, s2,
                      ex_mem.store_data);
            check_val("issue pc", m_inst.pc, ex_mem.pc);
            check_val("issue inst_class", m_inst.inst_class, ex_mem.inst_class);
            check_val("issue funct3", m_inst.funct3, ex_mem.funct3);
            check_val("issue rd", m_inst.rd, ex_mem.rd);
            if (rexp.update) begin
                check_val("branch redirect.target", rexp.target, redirect.target);
            end
            // stalled instruction stays put
            if (held) begin
                check_val("backpressure hold pc", last_pc, ex_mem.pc);
            end
        end
        last_pc = ex_mem.pc;
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        check_outputs();
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        seed         = 32'hf584b9fc;
        reset        = 1'b1;
        branch_flush = 1'b0;
        valid_id_ex  = 1'b0;
        ready_ex_mem = 1'b0;
        id_ex        = '0;
        mem_bypass   = '0;
        wb_bypass    = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        repeat (test_cycles) begin
            @(posedge clk);
            drive_random();
        end
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    branch_flush,
    input  logic                    valid_id_ex,
    input  logic                    ready_ex_mem,
    input  ex_stage_pkg::id_ex_t    id_ex,
    input  ex_stage_pkg::bypass_t   mem_bypass,
    input  ex_stage_pkg::bypass_t   wb_bypass,
    output logic                    ready_id_ex,
    output logic                    valid_ex_mem,
    output ex_stage_pkg::ex_mem_t   ex_mem,
    output ex_stage_pkg::redirect_t redirect
);

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    logic      ex_valid;
    id_ex_t    ex_inst;
    data_t     src1;
    data_t     src2;
    alu_op_e   op;
    data_t     opnd_a;
    data_t     opnd_b;
    logic      word_result;
    logic      word_shift_right;
    data_t     alu_result;
    redirect_t redirect_raw;

    // single-cycle ALU, no EX stall source
    assign ready_id_ex = ready_ex_mem;

    ex_issue_reg ex_issue_reg_i (
        .clk          (clk),
        .reset        (reset),
        .branch_flush (branch_flush),
        .ready_ex_mem (ready_ex_mem),
        .valid_id_ex  (valid_id_ex),
        .id_ex        (id_ex),
        .ex_valid     (ex_valid),
        .ex_inst      (ex_inst)
    );

    operand_forward operand_forward_i (
        .ex_inst    (ex_inst),
        .mem_bypass (mem_bypass),
        .wb_bypass  (wb_bypass),
        .src1       (src1),
        .src2       (src2)
    );

    alu_decode alu_decode_i (
        .ex_inst          (ex_inst),
        .src1             (src1),
        .src2             (src2),
        .op               (op),
        .opnd_a           (opnd_a),
        .opnd_b           (opnd_b),
        .word_result      (word_result),
        .word_shift_right (word_shift_right)
    );

    ex_alu ex_alu_i (
        .op               (op),
        .opnd_a           (opnd_a),
        .opnd_b           (opnd_b),
        .word_result      (word_result),
        .word_shift_right (word_shift_right),
        .result           (alu_result)
    );

    // compare runs beside the ALU, not through it
    branch_unit branch_unit_i (
        .ex_inst  (ex_inst),
        .src1     (src1),
        .src2     (src2),
        .redirect (redirect_raw)
    );

    ex_result ex_result_i (
        .ex_valid     (ex_valid),
        .ready_ex_mem (ready_ex_mem),
        .ex_inst      (ex_inst),
        .src2         (src2),
        .alu_result   (alu_result),
        .redirect_raw (redirect_raw),
        .valid_ex_mem (valid_ex_mem),
        .ex_mem       (ex_mem),
        .redirect     (redirect)
    );

endmodule

`default_nettype wire

/* hdl/ex_result.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_result (
    input  logic                    ex_valid,
    input  logic                    ready_ex_mem,
    input  ex_stage_pkg::id_ex_t    ex_inst,
    input  rv_isa_pkg::data_t       src2,
    input  rv_isa_pkg::data_t       alu_result,
    input  ex_stage_pkg::redirect_t redirect_raw,
    output logic                    valid_ex_mem,
    output ex_stage_pkg::ex_mem_t   ex_mem,
    output ex_stage_pkg::redirect_t redirect
);

    assign valid_ex_mem = ex_valid;

    // MEM bundle
    // store data is the forwarded rs2
    assign ex_mem.pc         = ex_inst.pc;
    assign ex_mem.inst_class = ex_inst.inst_class;
    assign ex_mem.funct3     = ex_inst.funct3;
    assign ex_mem.rd         = ex_inst.rd;
    assign ex_mem.alu_result = alu_result;
    assign ex_mem.store_data = src2;

    // fire only on the edge the instruction leaves EX
    // a stalled branch redirects once
    assign redirect.update = redirect_raw.update && ex_valid && ready_ex_mem;
    assign redirect.target = redirect_raw.target;

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  ex_stage_pkg::id_ex_t    ex_inst,
    input  rv_isa_pkg::data_t       src1,
    input  rv_isa_pkg::data_t       src2,
    output ex_stage_pkg::redirect_t redirect
);

    import rv_isa_pkg::*;

    logic  is_branch;
    logic  is_jalr;
    logic  predicted;
    logic  taken;
    data_t tgt_base;
    data_t tgt_off;

    assign is_branch = ex_inst.inst_class == cls_branch;
    assign is_jalr   = ex_inst.inst_class == cls_jalr;

    // backward taken, forward not taken
    assign predicted = ex_inst.imm[imm_sign_bit];

    // real outcome
    always_comb begin
        case (ex_inst.funct3)
            f3_beq:  taken = src1 == src2;
            f3_bne:  taken = src1 != src2;
            f3_blt:  taken = $signed(src1) < $signed(src2);
            f3_bge:  taken = $signed(src1) >= $signed(src2);
            f3_bltu: taken = src1 < src2;
            f3_bgeu: taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    // jal already redirected in fetch
    assign redirect.update = is_jalr || (is_branch && (taken != predicted));

    // one adder for all three targets
    // jalr: rs1 + imm, bit 0 kept
    // predicted taken but fell through: pc + 4
    // predicted not taken but taken: pc + imm
    assign tgt_base = is_jalr ? src1 : ex_inst.pc;
    assign tgt_off  = (is_branch && predicted) ? inst_len : ex_inst.imm;

    assign redirect.target = tgt_base + tgt_off;

endmodule

`default_nettype wire

/* hdl/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_stage_pkg::alu_op_e op,
    input  rv_isa_pkg::data_t     opnd_a,
    input  rv_isa_pkg::data_t     opnd_b,
    input  logic                  word_result,
    input  logic                  word_shift_right,
    output rv_isa_pkg::data_t     result
);

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    data_t raw;
    logic  lt_s;
    logic  lt_u;

    assign lt_s = $signed(opnd_a) < $signed(opnd_b);
    assign lt_u = opnd_a < opnd_b;

    // full-width result
    // shifts only look at the low 6 bits, decode already masked them
    always_comb begin
        case (op)
            alu_add:  raw = opnd_a + opnd_b;
            alu_sub:  raw = opnd_a - opnd_b;
            alu_slt:  raw = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: raw = {{(xlen-1){1'b0}}, lt_u};
            alu_and:  raw = opnd_a & opnd_b;
            alu_or:   raw = opnd_a | opnd_b;
            alu_xor:  raw = opnd_a ^ opnd_b;
            alu_sll:  raw = opnd_a << opnd_b[5:0];
            alu_srl:  raw = opnd_a >> opnd_b[5:0];
            alu_sra:  raw = $signed(opnd_a) >>> opnd_b[5:0];
            default:  raw = '0;
        endcase
    end

    // word formatting
    // right word shifts land in the upper half, everything else in the lower
    always_comb begin
        if (word_shift_right) begin
            result = {{32{raw[63]}}, raw[63:32]};
        end else if (word_result) begin
            result = {{32{raw[31]}}, raw[31:0]};
        end else begin
            result = raw;
        end
    end

endmodule

`default_nettype wire

/* hdl/alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
    input  ex_stage_pkg::id_ex_t  ex_inst,
    input  rv_isa_pkg::data_t     src1,
    input  rv_isa_pkg::data_t     src2,
    output ex_stage_pkg::alu_op_e op,
    output rv_isa_pkg::data_t     opnd_a,
    output rv_isa_pkg::data_t     opnd_b,
    output logic                  word_result,
    output logic                  word_shift_right
);

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    logic is_reg_form;
    logic is_arith;
    logic is_shift;
    logic alt;

    // op and op_w take rs2, the imm forms take imm
    assign is_reg_form = (ex_inst.inst_class == cls_op) || (ex_inst.inst_class == cls_op_w);
    assign is_arith    = is_reg_form
                      || (ex_inst.inst_class == cls_op_imm)
                      || (ex_inst.inst_class == cls_op_imm_w);
    assign is_shift    = is_arith && (ex_inst.funct3 == f3_sll || ex_inst.funct3 == f3_sr);
    assign alt         = ex_inst.imm[imm_alt_bit];

    assign word_result = (ex_inst.inst_class == cls_op_w)
                      || (ex_inst.inst_class == cls_op_imm_w);
    // srlw/sraw run on the low word parked in the upper half
    assign word_shift_right = word_result && (ex_inst.funct3 == f3_sr);

    // operand a
    always_comb begin
        case (ex_inst.inst_class)
            cls_lui:                      opnd_a = '0;
            cls_auipc, cls_jal, cls_jalr: opnd_a = ex_inst.pc;
            default: begin
                if (word_shift_right) begin
                    opnd_a = {src1[31:0], 32'b0};
                end else begin
                    opnd_a = src1;
                end
            end
        endcase
    end

    // operand b
    // shift amounts masked to 6 bits, 5 for word forms
    always_comb begin
        case (ex_inst.inst_class)
            cls_jal, cls_jalr: opnd_b = inst_len;
            cls_op_imm: opnd_b = is_shift ? {58'b0, ex_inst.imm[5:0]} : ex_inst.imm;
            cls_op_imm_w: opnd_b = is_shift ? {59'b0, ex_inst.imm[4:0]} : ex_inst.imm;
            cls_op: opnd_b = is_shift ? {58'b0, src2[5:0]} : src2;
            cls_op_w: opnd_b = is_shift ? {59'b0, src2[4:0]} : src2;
            cls_lui, cls_auipc, cls_load, cls_store: opnd_b = ex_inst.imm;
            // branch: compare operands
            default: opnd_b = src2;
        endcase
    end

    // op select
    // lui, auipc, links and addresses all add
    always_comb begin
        op = alu_add;
        if (ex_inst.inst_class == cls_branch) begin
            op = alu_sub;
        end else if (is_arith) begin
            case (ex_inst.funct3)
                f3_add:  op = (is_reg_form && alt) ? alu_sub : alu_add;
                f3_sll:  op = alu_sll;
                f3_slt:  op = alu_slt;
                f3_sltu: op = alu_sltu;
                f3_xor:  op = alu_xor;
                f3_sr:   op = alt ? alu_sra : alu_srl;
                f3_or:   op = alu_or;
                f3_and:  op = alu_and;
                default: op = alu_add;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  ex_stage_pkg::id_ex_t  ex_inst,
    input  ex_stage_pkg::bypass_t mem_bypass,
    input  ex_stage_pkg::bypass_t wb_bypass,
    output rv_isa_pkg::data_t     src1,
    output rv_isa_pkg::data_t     src2
);

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    logic rs2_live;

    // bypass select for one source index
    // MEM is younger than WB, so it takes priority
    function automatic data_t pick(input reg_idx_t idx, input data_t rf_val,
                                   input bypass_t mem_src, input bypass_t wb_src);
        data_t val;
        val = rf_val;
        if (idx != '0) begin
            if (mem_src.wr && mem_src.rd == idx) begin
                val = mem_src.data;
            end else if (wb_src.wr && wb_src.rd == idx) begin
                val = wb_src.data;
            end
        end
        return val;
    endfunction

    // rs2 field is garbage for I/U/J formats
    always_comb begin
        case (ex_inst.inst_class)
            cls_branch, cls_store, cls_op, cls_op_w: rs2_live = 1'b1;
            default:                                 rs2_live = 1'b0;
        endcase
    end

    // rs1 is always forwarded; lui/auipc/jal ignore src1 downstream
    assign src1 = pick(ex_inst.rs1, ex_inst.src_a, mem_bypass, wb_bypass);

    assign src2 = rs2_live ? pick(ex_inst.rs2, ex_inst.src_b, mem_bypass, wb_bypass)
                           : ex_inst.src_b;

endmodule

`default_nettype wire

/* hdl/ex_issue_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_issue_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 branch_flush,
    input  logic                 ready_ex_mem,
    input  logic                 valid_id_ex,
    input  ex_stage_pkg::id_ex_t id_ex,
    output logic                 ex_valid,
    output ex_stage_pkg::id_ex_t ex_inst
);

    // valid bit
    // flush wins over back-pressure
    always_ff @(posedge clk) begin
        if (reset || branch_flush) begin
            ex_valid <= 1'b0;
        end else if (ready_ex_mem) begin
            ex_valid <= valid_id_ex;
        end
    end

    // payload
    // only captured for a real transfer, left stale otherwise
    always_ff @(posedge clk) begin
        if (ready_ex_mem && valid_id_ex) begin
            ex_inst <= id_ex;
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_stage_pkg.sv */
`default_nettype none

package ex_stage_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // decoded instruction handed over by ID
    typedef struct packed {
        rv_isa_pkg::data_t       pc;
        rv_isa_pkg::inst_class_e inst_class;
        rv_isa_pkg::funct3_t     funct3;
        rv_isa_pkg::reg_idx_t    rd;
        rv_isa_pkg::reg_idx_t    rs1;
        rv_isa_pkg::reg_idx_t    rs2;
        // register file values read in ID
        rv_isa_pkg::data_t       src_a;
        rv_isa_pkg::data_t       src_b;
        // already sign extended by ID
        rv_isa_pkg::data_t       imm;
    } id_ex_t;

    // one later stage about to write the register file
    typedef struct packed {
        logic                 wr;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::data_t    data;
    } bypass_t;

    // towards MEM
    typedef struct packed {
        rv_isa_pkg::data_t       pc;
        rv_isa_pkg::inst_class_e inst_class;
        rv_isa_pkg::funct3_t     funct3;
        rv_isa_pkg::reg_idx_t    rd;
        // also the load/store address
        rv_isa_pkg::data_t       alu_result;
        rv_isa_pkg::data_t       store_data;
    } ex_mem_t;

    // fetch restart request
    typedef struct packed {
        logic              update;
        rv_isa_pkg::data_t target;
    } redirect_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // datapath width, rv64 only
    localparam int xlen = 64;

    typedef logic [xlen-1:0] data_t;

    // x0 reads as zero, never forwarded
    typedef logic [4:0] reg_idx_t;

    typedef logic [2:0] funct3_t;

    // one code per major opcode group seen by EX
    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_op_imm_w,
        cls_op_w
    } inst_class_e;

    // branch compares
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // integer ops, register and immediate forms
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // funct7[5] lands here in the decoded immediate
    localparam int imm_alt_bit = 10;
    // sign of the branch offset doubles as the static prediction
    localparam int imm_sign_bit = 12;

    localparam data_t inst_len = 64'd4;

endpackage

`default_nettype wire
